/* logic/decode_types_pkg.sv */
// *******************
// shared types for the decode stage and its testbench
// use by scoped name, decode_types_pkg::control_t and friends
// *******************
`default_nettype none

package decode_types_pkg;

    // basic words and register indices
    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;

    // vector class reserved, scalar decode only tags RC_SCALAR
    typedef enum logic {
        RC_SCALAR = 1'b0,
        RC_VECTOR = 1'b1
    } regclass_t;

    // a source register as seen by later hazard logic
    typedef struct packed {
        regclass_t regclass;
        reg_idx_t  regidx;
    } reg_ref_t;

    // rv32i major opcodes, bits 6:0
    typedef enum logic [6:0] {
        LUI     = 7'b0110111,
        AUIPC   = 7'b0010111,
        JAL     = 7'b1101111,
        JALR    = 7'b1100111,
        BRANCH  = 7'b1100011,
        LOAD    = 7'b0000011,
        STORE   = 7'b0100011,
        IMMED   = 7'b0010011,
        REGREG  = 7'b0110011,
        MISCMEM = 7'b0001111,
        SYSTEM  = 7'b1110011
    } opcode_t;

    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_AND  = 4'd2,
        ALU_OR   = 4'd3,
        ALU_XOR  = 4'd4,
        ALU_SLL  = 4'd5,
        ALU_SRL  = 4'd6,
        ALU_SRA  = 4'd7,
        ALU_SLT  = 4'd8,
        ALU_SLTU = 4'd9
    } alu_op_t;

    // encodings follow funct3 so the decoder can cast directly
    typedef enum logic [2:0] {
        LB  = 3'b000,
        LH  = 3'b001,
        LW  = 3'b010,
        LBU = 3'b100,
        LHU = 3'b101
    } load_type_t;

    typedef enum logic [2:0] {
        BEQ  = 3'b000,
        BNE  = 3'b001,
        BLT  = 3'b100,
        BGE  = 3'b101,
        BLTU = 3'b110,
        BGEU = 3'b111
    } branch_type_t;

    // writeback source select
    typedef enum logic [2:0] {
        W_ALU   = 3'd0,
        W_LOAD  = 3'd1,
        W_PC4   = 3'd2,
        W_IMM_U = 3'd3,
        W_CSR   = 3'd4
    } w_sel_t;

    // every immediate format, built whatever the opcode
    typedef struct packed {
        word_t      imm_I;
        word_t      imm_S;
        word_t      imm_SB;
        word_t      imm_U;
        word_t      imm_UJ;
        logic [4:0] shamt;
        logic [4:0] zimm;
    } imm_set_t;

    // op is funct3 of MUL..REMU
    typedef struct packed {
        logic       select;
        logic [2:0] op;
    } rv32m_control_t;

    typedef struct packed {
        logic illegal_insn;
        logic ret_insn;
        logic breakpoint;
        logic ecall_insn;
        logic csr_swap;
        logic csr_set;
        logic csr_clr;
        logic csr_imm;
        logic csr_rw_valid;
        logic wfi;
        logic ifence;
    } priv_flags_t;

    // full decode record handed to execute
    typedef struct packed {
        // memory and control flow
        logic           dwen;
        logic           dren;
        logic           branch;
        logic           jump;
        logic           j_sel;
        logic           ex_pc_sel;
        logic           halt;
        // alu, a_sel 1 picks pc, b_sel 1 picks an immediate
        alu_op_t        alu_op;
        logic           alu_a_sel;
        logic           alu_b_sel;
        logic           imm_shamt_sel;
        // writeback and registers
        logic           wen;
        w_sel_t         w_sel;
        reg_idx_t       rd;
        reg_ref_t       rs1;
        reg_ref_t       rs2;
        // types and extension
        load_type_t     load_type;
        branch_type_t   branch_type;
        opcode_t        opcode;
        rv32m_control_t rv32m_control;
        imm_set_t       imms;
        priv_flags_t    priv;
        logic [11:0]    csr_addr;
    } control_t;

endpackage

`default_nettype wire

/* logic/control_unit.sv */
// *******************
// main rv32im decoder, opcode and function fields to control flags
// *******************
`default_nettype none

module control_unit #(
    parameter bit m_ext_en = 1'b1
) (
    input  decode_types_pkg::word_t    instr,
    output decode_types_pkg::control_t ctrl
);

    decode_types_pkg::opcode_t opcode;
    logic [2:0]                funct3;
    logic [6:0]                funct7;
    logic [11:0]               funct12;
    logic                      is_halt;

    assign opcode  = decode_types_pkg::opcode_t'(instr[6:0]);
    assign funct3  = instr[14:12];
    assign funct7  = instr[31:25];
    assign funct12 = instr[31:20];
    // all ones word stops the core, not an exception
    assign is_halt = (instr == '1);

    // shared funct3 map for reg-reg and reg-imm
    function automatic decode_types_pkg::alu_op_t alu_sel(
        input logic [2:0] f3,
        input logic       alt
    );
        decode_types_pkg::alu_op_t op;
        case (f3)
            3'b000:  op = alt ? decode_types_pkg::ALU_SUB : decode_types_pkg::ALU_ADD;
            3'b001:  op = decode_types_pkg::ALU_SLL;
            3'b010:  op = decode_types_pkg::ALU_SLT;
            3'b011:  op = decode_types_pkg::ALU_SLTU;
            3'b100:  op = decode_types_pkg::ALU_XOR;
            3'b101:  op = alt ? decode_types_pkg::ALU_SRA : decode_types_pkg::ALU_SRL;
            3'b110:  op = decode_types_pkg::ALU_OR;
            default: op = decode_types_pkg::ALU_AND;
        endcase
        return op;
    endfunction

    always_comb begin
        // immediates and sources stay zero, filled in by the wrapper
        ctrl          = '0;
        ctrl.opcode   = opcode;
        ctrl.rd       = instr[11:7];
        ctrl.csr_addr = funct12;
        ctrl.halt     = is_halt;
        ctrl.w_sel    = decode_types_pkg::W_ALU;
        ctrl.alu_op   = decode_types_pkg::ALU_ADD;

        case (opcode)
            decode_types_pkg::LUI: begin
                ctrl.wen   = 1'b1;
                ctrl.w_sel = decode_types_pkg::W_IMM_U;
            end
            decode_types_pkg::AUIPC: begin
                // pc + imm_U through the alu
                ctrl.wen       = 1'b1;
                ctrl.alu_a_sel = 1'b1;
                ctrl.alu_b_sel = 1'b1;
            end
            decode_types_pkg::JAL: begin
                ctrl.wen       = 1'b1;
                ctrl.jump      = 1'b1;
                ctrl.j_sel     = 1'b1;
                ctrl.ex_pc_sel = 1'b1;
                ctrl.w_sel     = decode_types_pkg::W_PC4;
            end
            decode_types_pkg::JALR: begin
                // target is rs1 + imm_I from the alu
                ctrl.wen       = 1'b1;
                ctrl.jump      = 1'b1;
                ctrl.ex_pc_sel = 1'b1;
                ctrl.alu_b_sel = 1'b1;
                ctrl.w_sel     = decode_types_pkg::W_PC4;
                ctrl.priv.illegal_insn = (funct3 != 3'b000);
            end
            decode_types_pkg::BRANCH: begin
                ctrl.branch      = 1'b1;
                ctrl.branch_type = decode_types_pkg::branch_type_t'(funct3);
                // 010 and 011 unused
                ctrl.priv.illegal_insn = (funct3[2:1] == 2'b01);
            end
            decode_types_pkg::LOAD: begin
                ctrl.dren      = 1'b1;
                ctrl.wen       = 1'b1;
                ctrl.alu_b_sel = 1'b1;
                ctrl.w_sel     = decode_types_pkg::W_LOAD;
                ctrl.load_type = decode_types_pkg::load_type_t'(funct3);
                ctrl.priv.illegal_insn = (funct3 == 3'b011) || (funct3[2:1] == 2'b11);
            end
            decode_types_pkg::STORE: begin
                ctrl.dwen      = 1'b1;
                ctrl.alu_b_sel = 1'b1;
                // only sb, sh, sw
                ctrl.priv.illegal_insn = (funct3 > 3'b010);
            end
            decode_types_pkg::IMMED: begin
                ctrl.wen           = 1'b1;
                ctrl.alu_b_sel     = 1'b1;
                ctrl.imm_shamt_sel = (funct3[1:0] == 2'b01);
                // bit 30 only selects srai, addi has no subtract form
                ctrl.alu_op = alu_sel(funct3, funct7[5] && (funct3 == 3'b101));
                if (funct3 == 3'b001) begin
                    ctrl.priv.illegal_insn = (funct7 != 7'b0000000);
                end else if (funct3 == 3'b101) begin
                    ctrl.priv.illegal_insn = (funct7 != 7'b0000000) && (funct7 != 7'b0100000);
                end
            end
            decode_types_pkg::REGREG: begin
                ctrl.wen    = 1'b1;
                ctrl.alu_op = alu_sel(funct3, funct7[5]);
                if (funct7 == 7'b0000001) begin
                    // mul/div unit takes over the result
                    if (m_ext_en) begin
                        ctrl.rv32m_control.select = 1'b1;
                        ctrl.rv32m_control.op     = funct3;
                    end else begin
                        ctrl.priv.illegal_insn = 1'b1;
                    end
                end else if (funct7 == 7'b0100000) begin
                    // sub and sra only
                    ctrl.priv.illegal_insn = (funct3 != 3'b000) && (funct3 != 3'b101);
                end else if (funct7 != 7'b0000000) begin
                    ctrl.priv.illegal_insn = 1'b1;
                end
            end
            decode_types_pkg::MISCMEM: begin
                // fence is a no-op in order, fence.i flushes fetch
                ctrl.priv.ifence       = (funct3 == 3'b001);
                ctrl.priv.illegal_insn = (funct3[2:1] != 2'b00);
            end
            decode_types_pkg::SYSTEM: begin
                if (funct3 == 3'b000) begin
                    case (funct12)
                        12'h000: ctrl.priv.ecall_insn   = 1'b1;
                        12'h001: ctrl.priv.breakpoint   = 1'b1;
                        12'h302: ctrl.priv.ret_insn     = 1'b1;
                        12'h105: ctrl.priv.wfi          = 1'b1;
                        default: ctrl.priv.illegal_insn = 1'b1;
                    endcase
                end else begin
                    ctrl.wen           = 1'b1;
                    ctrl.w_sel         = decode_types_pkg::W_CSR;
                    ctrl.priv.csr_imm  = funct3[2];
                    ctrl.priv.csr_swap = (funct3[1:0] == 2'b01);
                    ctrl.priv.csr_set  = (funct3[1:0] == 2'b10);
                    ctrl.priv.csr_clr  = (funct3[1:0] == 2'b11);
                    ctrl.priv.illegal_insn = (funct3[1:0] == 2'b00);
                    // set/clr with x0 or zimm 0 only reads the csr
                    ctrl.priv.csr_rw_valid = !ctrl.priv.illegal_insn &&
                        ((funct3[1:0] == 2'b01) || (instr[19:15] != 5'd0));
                end
            end
            default: begin
                ctrl.priv.illegal_insn = !is_halt;
            end
        endcase

        // trap path, no architectural side effects
        if (ctrl.priv.illegal_insn) begin
            ctrl.wen  = 1'b0;
            ctrl.dwen = 1'b0;
            ctrl.dren = 1'b0;
        end
    end

endmodule

`default_nettype wire

/* logic/imm_extract.sv */
// *******************
// builds every rv32i immediate format from one instruction word
// *******************
`default_nettype none

module imm_extract (
    input  decode_types_pkg::word_t    instr,
    output decode_types_pkg::imm_set_t imms
);

    logic sign;

    // bit 31 carries the sign for every format
    assign sign = instr[31];

    always_comb begin
        // loads, jalr, reg-imm alu, csr address
        imms.imm_I = {{20{sign}}, instr[31:20]};

        // stores, offset split around rd
        imms.imm_S = {{20{sign}}, instr[31:25], instr[11:7]};

        // branches, halfword aligned
        imms.imm_SB = {
            {19{sign}},
            instr[31],
            instr[7],
            instr[30:25],
            instr[11:8],
            1'b0
        };

        // lui and auipc, upper twenty bits
        imms.imm_U = {instr[31:12], 12'b0};

        // jal, scrambled 20-bit offset
        imms.imm_UJ = {
            {11{sign}},
            instr[31],
            instr[19:12],
            instr[20],
            instr[30:21],
            1'b0
        };

        // shift amount for slli/srli/srai
        imms.shamt = instr[24:20];

        // csr immediate sits in the rs1 field
        imms.zimm = instr[19:15];
    end

endmodule

`default_nettype wire

/* logic/scalar_decode.sv */
// *******************
// scalar decode, merges control unit and immediates into one record
// *******************
`default_nettype none

module scalar_decode #(
    parameter bit m_ext_en = 1'b1
) (
    input  decode_types_pkg::word_t    instr,
    output decode_types_pkg::control_t control_out
);

    decode_types_pkg::control_t cu_ctrl;
    decode_types_pkg::imm_set_t imms;
    decode_types_pkg::reg_ref_t rs1_ref;
    decode_types_pkg::reg_ref_t rs2_ref;
    logic                       reads_rs2;

    // input is already expanded if it came from a compressed word
    control_unit #(
        .m_ext_en (m_ext_en)
    ) control_unit_inst (
        .instr (instr),
        .ctrl  (cu_ctrl)
    );

    imm_extract imm_extract_inst (
        .instr (instr),
        .imms  (imms)
    );

    // only R, S and B formats carry a real rs2
    always_comb begin
        case (cu_ctrl.opcode)
            decode_types_pkg::REGREG,
            decode_types_pkg::STORE,
            decode_types_pkg::BRANCH: reads_rs2 = 1'b1;
            default:                  reads_rs2 = 1'b0;
        endcase
    end

    // rs1 field read raw, x0 already means no dependency
    assign rs1_ref = '{
        regclass: decode_types_pkg::RC_SCALAR,
        regidx:   instr[19:15]
    };

    // U, J and I formats reuse bits 24:20, drop them here
    assign rs2_ref = '{
        regclass: decode_types_pkg::RC_SCALAR,
        regidx:   reads_rs2 ? instr[24:20] : 5'd0
    };

    always_comb begin
        control_out      = cu_ctrl;
        control_out.imms = imms;
        control_out.rs1  = rs1_ref;
        control_out.rs2  = rs2_ref;
    end

endmodule

`default_nettype wire

/* logic/decode_latch.sv */
// *******************
// decode to execute register, stall holds and flush drops valid
// *******************
`default_nettype none

module decode_latch (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       stall,
    input  logic                       flush,
    input  logic                       in_valid,
    input  decode_types_pkg::control_t in_ctrl,
    output decode_types_pkg::control_t out_ctrl,
    output logic                       out_valid
);

    // reset record is all zeros, so wen, dwen and dren start inactive
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_ctrl  <= '0;
            out_valid <= 1'b0;
        end else if (flush) begin
            // flush beats stall, stale record stays but is not valid
            out_valid <= 1'b0;
        end else if (!stall) begin
            out_ctrl  <= in_ctrl;
            out_valid <= in_valid;
        end
    end

    // upstream holds instr while stalled, no skid buffer here
    stall_holds: assert property (
        @(posedge clk) disable iff (!rst_n)
        (stall && !flush) |=> ($stable(out_ctrl) && $stable(out_valid))
    );

    flush_kills: assert property (
        @(posedge clk) disable iff (!rst_n)
        flush |=> !out_valid
    );

    // an illegal word reaching execute never writes anything
    no_illegal_write: assert property (
        @(posedge clk) disable iff (!rst_n)
        (out_valid && out_ctrl.priv.illegal_insn) |-> !(out_ctrl.wen || out_ctrl.dwen)
    );

endmodule

`default_nettype wire

/* logic/decode_stage.sv */
// *******************
// decode stage top, one cycle from instr to registered record
// *******************
`default_nettype none

module decode_stage #(
    parameter bit m_ext_en = 1'b1
) (
    input  logic                       clk,
    input  logic                       rst_n,
    input  decode_types_pkg::word_t    instr,
    input  logic                       instr_valid,
    input  logic                       stall,
    input  logic                       flush,
    output decode_types_pkg::control_t ctrl,
    output logic                       ctrl_valid
);

    // combinational decode result
    decode_types_pkg::control_t dec_ctrl;

    scalar_decode #(
        .m_ext_en (m_ext_en)
    ) scalar_decode_inst (
        .instr       (instr),
        .control_out (dec_ctrl)
    );

    // stall and flush come from hazard logic outside
    decode_latch decode_latch_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .stall     (stall),
        .flush     (flush),
        .in_valid  (instr_valid),
        .in_ctrl   (dec_ctrl),
        .out_ctrl  (ctrl),
        .out_valid (ctrl_valid)
    );

endmodule

`default_nettype wire

/* verification/decode_stage_tb.sv */
// *******************
// testbench for decode_stage, replays verification/decode_stim.txt
// one line per cycle, checked one edge later against a latch model
// *******************
`default_nettype none

module decode_stage_tb;

    // one parsed stimulus line, inputs first then expected fields
    typedef struct packed {
        decode_types_pkg::word_t       instr;
        logic                          valid;
        logic                          stall;
        logic                          flush;
        decode_types_pkg::alu_op_t     alu_op;
        decode_types_pkg::w_sel_t      w_sel;
        logic                          wen;
        logic                          dwen;
        logic                          dren;
        decode_types_pkg::reg_idx_t    rd;
        decode_types_pkg::reg_ref_t    rs1;
        decode_types_pkg::reg_ref_t    rs2;
        decode_types_pkg::word_t       imm;
        decode_types_pkg::load_type_t  load_type;
        logic                          m_sel;
        decode_types_pkg::priv_flags_t priv;
    } stim_line_t;

    logic                       clk;
    logic                       rst_n;
    decode_types_pkg::word_t    instr;
    logic                       instr_valid;
    logic                       stall;
    logic                       flush;
    decode_types_pkg::control_t ctrl;
    logic                       ctrl_valid;

    stim_line_t stim_q[$];
    int         line_total;
    logic       loaded;

    decode_stage #(
        .m_ext_en (1'b1)
    ) decode_stage_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr       (instr),
        .instr_valid (instr_valid),
        .stall       (stall),
        .flush       (flush),
        .ctrl        (ctrl),
        .ctrl_valid  (ctrl_valid)
    );

    // period 4
    always #2 clk = ~clk;

    task automatic fail_run();
        $display("sim failed");
        $fatal(1);
    endtask

    task automatic check_valid(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("** Error at %0t: %s got %0b expected %0b", $time, name, got, exp);
            fail_run();
        end
    endtask

    task automatic check_alu(
        input decode_types_pkg::alu_op_t got,
        input decode_types_pkg::alu_op_t exp
    );
        if (got !== exp) begin
            $display("** Error at %0t: alu_op got %0d expected %0d", $time, got, exp);
            fail_run();
        end
    endtask

    task automatic check_wsel(
        input decode_types_pkg::w_sel_t got,
        input decode_types_pkg::w_sel_t exp
    );
        if (got !== exp) begin
            $display("** Error at %0t: w_sel got %0d expected %0d", $time, got, exp);
            fail_run();
        end
    endtask

    task automatic check_idx(
        input string                      name,
        input decode_types_pkg::reg_idx_t got,
        input decode_types_pkg::reg_idx_t exp
    );
        if (got !== exp) begin
            $display("** Error at %0t: %s got x%0d expected x%0d", $time, name, got, exp);
            fail_run();
        end
    endtask

    // class bit and index together
    task automatic check_reg(
        input string                      name,
        input decode_types_pkg::reg_ref_t got,
        input decode_types_pkg::reg_ref_t exp
    );
        if (got !== exp) begin
            $display("** Error at %0t: %s got %0h expected %0h", $time, name, got, exp);
            fail_run();
        end
    endtask

    task automatic check_word(
        input string                   name,
        input decode_types_pkg::word_t got,
        input decode_types_pkg::word_t exp
    );
        if (got !== exp) begin
            $display("** Error at %0t: %s got %h expected %h", $time, name, got, exp);
            fail_run();
        end
    endtask

    task automatic check_load(
        input decode_types_pkg::load_type_t got,
        input decode_types_pkg::load_type_t exp
    );
        if (got !== exp) begin
            $display("** Error at %0t: load_type got %0d expected %0d", $time, got, exp);
            fail_run();
        end
    endtask

    task automatic check_priv(
        input decode_types_pkg::priv_flags_t got,
        input decode_types_pkg::priv_flags_t exp
    );
        if (got !== exp) begin
            $display("** Error at %0t: priv flags got %h expected %h", $time, got, exp);
            fail_run();
        end
    endtask

    // immediate format implied by the rv32i opcode
    function automatic decode_types_pkg::word_t pick_imm(
        input decode_types_pkg::word_t    word,
        input decode_types_pkg::imm_set_t imms
    );
        decode_types_pkg::word_t sel;
        case (word[6:0])
            7'b0100011:             sel = imms.imm_S;
            7'b1100011:             sel = imms.imm_SB;
            7'b0110111, 7'b0010111: sel = imms.imm_U;
            7'b1101111:             sel = imms.imm_UJ;
            default:                sel = imms.imm_I;
        endcase
        return sel;
    endfunction

    // fills stim_q, skips comment and blank lines
    task automatic load_stim();
        int                      fd;
        int                      n;
        string                   text;
        decode_types_pkg::word_t w_instr;
        decode_types_pkg::word_t w_imm;
        int                      v, s, f, alu_i, wsel_i, wen_i, dwen_i, dren_i;
        int                      rd_i, rs1_i, rs2_i, lt_i, msel_i, priv_i;
        stim_line_t              e;
        fd = $fopen("verification/decode_stim.txt", "r");
        if (fd == 0) begin
            $display("could not open the stimulus file verification/decode_stim.txt");
            fail_run();
        end
        while ($fgets(text, fd) != 0) begin
            if (text.len() < 2 || text.getc(0) == "#") begin
                continue;
            end
            n = $sscanf(text, "%h %d %d %d %d %d %d %d %d %d %d %d %h %d %d %h",
                        w_instr, v, s, f, alu_i, wsel_i, wen_i, dwen_i, dren_i,
                        rd_i, rs1_i, rs2_i, w_imm, lt_i, msel_i, priv_i);
            if (n != 16) begin
                $display("stimulus line has %0d fields instead of 16: %s", n, text);
                fail_run();
            end
            e              = '0;
            e.instr        = w_instr;
            e.valid        = v[0];
            e.stall        = s[0];
            e.flush        = f[0];
            e.alu_op       = decode_types_pkg::alu_op_t'(alu_i[3:0]);
            e.w_sel        = decode_types_pkg::w_sel_t'(wsel_i[2:0]);
            e.wen          = wen_i[0];
            e.dwen         = dwen_i[0];
            e.dren         = dren_i[0];
            e.rd           = rd_i[4:0];
            e.rs1.regclass = decode_types_pkg::RC_SCALAR;
            e.rs1.regidx   = rs1_i[4:0];
            e.rs2.regclass = decode_types_pkg::RC_SCALAR;
            e.rs2.regidx   = rs2_i[4:0];
            e.imm          = w_imm;
            e.load_type    = decode_types_pkg::load_type_t'(lt_i[2:0]);
            e.m_sel        = msel_i[0];
            e.priv         = decode_types_pkg::priv_flags_t'(priv_i[10:0]);
            stim_q.push_back(e);
        end
        $fclose(fd);
    endtask

    // every registered output against the model record
    task automatic check_outputs(input stim_line_t e, input logic exp_valid);
        check_valid("ctrl_valid", ctrl_valid, exp_valid);
        check_alu(ctrl.alu_op, e.alu_op);
        check_wsel(ctrl.w_sel, e.w_sel);
        check_valid("wen", ctrl.wen, e.wen);
        check_valid("dwen", ctrl.dwen, e.dwen);
        check_valid("dren", ctrl.dren, e.dren);
        check_idx("rd", ctrl.rd, e.rd);
        check_reg("rs1", ctrl.rs1, e.rs1);
        check_reg("rs2", ctrl.rs2, e.rs2);
        check_word("immediate", pick_imm(e.instr, ctrl.imms), e.imm);
        check_load(ctrl.load_type, e.load_type);
        check_valid("rv32m select", ctrl.rv32m_control.select, e.m_sel);
        check_priv(ctrl.priv, e.priv);
    endtask

    initial begin : watchdog
        wait (loaded === 1'b1);
        #(line_total * 4 + 100);
        $display("watchdog expired before the stimulus finished");
        $display("sim failed");
        $fatal(1);
    end

    initial begin : main
        stim_line_t cur;
        stim_line_t exp_rec;
        logic       exp_valid;
        clk         = 1'b0;
        rst_n       = 1'b0;
        instr       = '0;
        instr_valid = 1'b0;
        stall       = 1'b0;
        flush       = 1'b0;
        loaded      = 1'b0;
        load_stim();
        line_total = stim_q.size();
        loaded     = 1'b1;

        // reset for 2 cycles, released just after the edge
        repeat (2) @(posedge clk);
        #1 rst_n = 1'b1;

        // zero record after reset
        exp_rec   = '0;
        exp_valid = 1'b0;
        check_outputs(exp_rec, exp_valid);

        while (stim_q.size() > 0) begin
            cur         = stim_q.pop_front();
            instr       = cur.instr;
            instr_valid = cur.valid;
            stall       = cur.stall;
            flush       = cur.flush;
            // latch model, flush first, then stall hold
            if (cur.flush) begin
                exp_valid = 1'b0;
            end else if (!cur.stall) begin
                exp_rec   = cur;
                exp_valid = cur.valid;
            end
            @(posedge clk);
            #1;
            check_outputs(exp_rec, exp_valid);
        end

        $display("sim passed");
        $finish;
    end

endmodule

`default_nettype wire

/* verification/decode_stim.txt */
# instr v stall flush alu_op w_sel wen dwen dren rd rs1 rs2 imm load_type m_sel priv
# enums as package values in decimal, imm and priv (priv_flags_t, illegal in bit 10) in hex
002081b3 1 0 0 0 0 1 0 0 3 1 2 00000002 0 0 000
404182b3 1 0 0 1 0 1 0 0 5 3 4 00000404 0 0 000
4012d333 1 0 0 7 0 1 0 0 6 5 1 00000401 0 0 000
003133b3 1 0 0 9 0 1 0 0 7 2 3 00000003 0 0 000
ffb08413 1 0 0 0 0 1 0 0 8 1 0 fffffffb 0 0 000
00c12483 1 0 0 0 1 1 0 1 9 2 0 0000000c 2 0 000
fe322c23 1 0 0 0 0 0 1 0 24 4 3 fffffff8 0 0 000
fe2088e3 1 0 0 0 0 0 0 0 17 1 2 fffffff0 0 0 000
12345537 1 0 0 0 3 1 0 0 10 8 0 12345000 0 0 000
ffdff0ef 1 0 0 0 2 1 0 0 1 31 0 fffffffc 0 0 000
00000073 1 0 0 0 0 0 0 0 0 0 0 00000000 0 0 080
300295f3 1 0 0 0 4 1 0 0 11 5 0 00000300 0 0 044
002081ff 1 0 0 0 0 0 0 0 3 1 0 00000002 0 0 400
02208633 1 0 0 0 0 1 0 0 12 1 2 00000022 0 1 000
# stall holds, flush clears valid, flush wins over stall, bubble loads with valid low
002081b3 1 0 0 0 0 1 0 0 3 1 2 00000002 0 0 000
404182b3 1 1 0 1 0 1 0 0 5 3 4 00000404 0 0 000
404182b3 1 0 0 1 0 1 0 0 5 3 4 00000404 0 0 000
00c12483 1 0 1 0 1 1 0 1 9 2 0 0000000c 2 0 000
00c12483 1 0 0 0 1 1 0 1 9 2 0 0000000c 2 0 000
ffb08413 1 1 1 0 0 1 0 0 8 1 0 fffffffb 0 0 000
ffb08413 0 0 0 0 0 1 0 0 8 1 0 fffffffb 0 0 000
ffb08413 1 0 0 0 0 1 0 0 8 1 0 fffffffb 0 0 000

/* files.f */
logic/decode_types_pkg.sv
logic/control_unit.sv
logic/imm_extract.sv
logic/scalar_decode.sv
logic/decode_latch.sv
logic/decode_stage.sv
verification/decode_stage_tb.sv
